// File: src/rob_pkg.sv
package rob_pkg;

    // queue geometry
    localparam int ROB_DEPTH     = 16;
    localparam int ENQ_WIDTH     = 2;
    localparam int COMMIT_WIDTH  = 2;
    localparam int WB_PORTS      = 2;
    localparam int NUM_PHYS_REGS = 64;

    // derived widths
    localparam int PREG_W    = 6;  // log2 of NUM_PHYS_REGS
    localparam int ROB_PTR_W = 4;  // log2 of ROB_DEPTH
    localparam int ROB_CNT_W = 5;  // count runs 0..ROB_DEPTH
    localparam int ENQ_CNT_W = 2;  // 0..ENQ_WIDTH
    localparam int RET_CNT_W = 2;  // 0..COMMIT_WIDTH

    localparam int NUM_ISSUE_UNITS = 3;  // alu, lsu, bru

    // life cycle of one slot
    typedef enum logic [1:0] {
        ENTRY_FREE   = 2'd0,
        ENTRY_READY  = 2'd1,  // waiting for issue
        ENTRY_ISSUED = 2'd2,  // in flight
        ENTRY_DONE   = 2'd3   // result written, waiting for commit
    } rob_status_e;

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_LSU = 2'd1,
        UNIT_BRU = 2'd2
    } unit_e;

    // decoded micro-op from rename
    typedef struct packed {
        logic              valid;
        logic [7:0]        opcode;
        unit_e             unit;
        logic [PREG_W-1:0] dest_preg;
        logic [PREG_W-1:0] src1_preg;
        logic [PREG_W-1:0] src2_preg;
        logic              uses_src2;  // src1 is always read
    } rob_uop_t;

    typedef struct packed {
        logic [7:0]        opcode;
        unit_e             unit;
        logic [PREG_W-1:0] dest_preg;
        logic [PREG_W-1:0] src1_preg;
        logic [PREG_W-1:0] src2_preg;
        logic              uses_src2;
        rob_status_e       status;
    } rob_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_PTR_W-1:0] ptr;  // slot to report back on writeback
        logic [7:0]           opcode;
        logic [PREG_W-1:0]    dest_preg;
        logic [PREG_W-1:0]    src1_preg;
        logic [PREG_W-1:0]    src2_preg;
    } rob_issue_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_PTR_W-1:0] ptr;
    } rob_wb_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_PTR_W-1:0] ptr;
    } issue_mark_t;

    // one retiring entry for the rrat
    typedef struct packed {
        logic              valid;
        logic [PREG_W-1:0] dest_preg;
        logic [7:0]        opcode;
    } rob_commit_t;

endpackage

// File: src/rob_ptr_ctrl.sv
`timescale 1ns/10ps

module rob_ptr_ctrl (
    input  logic                                  clk_in,
    input  logic                                  rst_N_in,
    input  logic                                  flush,
    input  logic [rob_pkg::ENQ_WIDTH-1:0]         enq_valid,
    input  logic [rob_pkg::RET_CNT_W-1:0]         retire_cnt,
    output logic [rob_pkg::ROB_PTR_W-1:0]         head,
    output logic [rob_pkg::ROB_PTR_W-1:0]         enq_ptr,
    output logic                                  enq_accept,
    output logic                                  rob_ready,
    output logic                                  empty
);

    import rob_pkg::*;

    logic [ROB_CNT_W-1:0] count;    // occupied slots
    logic [ENQ_CNT_W-1:0] enq_cnt;  // slots taken this cycle

    // room for a whole group, so a group is never split
    assign rob_ready  = (count <= ROB_CNT_W'(ROB_DEPTH - ENQ_WIDTH));
    assign empty      = (count == '0);
    assign enq_accept = rob_ready && (|enq_valid);

    always_comb begin
        enq_cnt = '0;
        if (enq_accept) begin
            for (int i = 0; i < ENQ_WIDTH; i++) begin
                if (enq_valid[i]) begin
                    enq_cnt = enq_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_N_in || flush) begin
            head    <= '0;
            enq_ptr <= '0;
            count   <= '0;
        end else begin
            head    <= head + ROB_PTR_W'(retire_cnt);     // wraps at ROB_DEPTH
            enq_ptr <= enq_ptr + ROB_PTR_W'(enq_cnt);
            count   <= count + ROB_CNT_W'(enq_cnt) - ROB_CNT_W'(retire_cnt);
        end
    end

endmodule

// File: src/rob_entry_store.sv
`timescale 1ns/10ps

module rob_entry_store (
    input  logic                                              clk_in,
    input  logic                                              rst_N_in,
    input  logic                                              flush,
    input  rob_pkg::rob_uop_t    [rob_pkg::ENQ_WIDTH-1:0]       enq_uops,
    input  logic                 [rob_pkg::ROB_PTR_W-1:0]       enq_ptr,
    input  logic                                              enq_accept,
    input  rob_pkg::rob_wb_t     [rob_pkg::WB_PORTS-1:0]        wb,
    input  rob_pkg::issue_mark_t [rob_pkg::NUM_ISSUE_UNITS-1:0] issue_marks,
    input  logic                 [rob_pkg::ROB_PTR_W-1:0]       head,
    input  logic                 [rob_pkg::RET_CNT_W-1:0]       retire_cnt,
    output rob_pkg::rob_entry_t  [rob_pkg::ROB_DEPTH-1:0]       entries
);

    import rob_pkg::*;

    rob_entry_t [ROB_DEPTH-1:0] entries_next;
    logic       [ROB_PTR_W-1:0] wr_slot;    // next tail slot for this group
    logic       [ROB_PTR_W-1:0] free_slot;

    always_comb begin
        entries_next = entries;
        wr_slot      = enq_ptr;
        free_slot    = head;

        // new micro-ops land at consecutive tail slots in slot order
        if (enq_accept) begin
            for (int i = 0; i < ENQ_WIDTH; i++) begin
                if (enq_uops[i].valid) begin
                    entries_next[wr_slot].opcode    = enq_uops[i].opcode;
                    entries_next[wr_slot].unit      = enq_uops[i].unit;
                    entries_next[wr_slot].dest_preg = enq_uops[i].dest_preg;
                    entries_next[wr_slot].src1_preg = enq_uops[i].src1_preg;
                    entries_next[wr_slot].src2_preg = enq_uops[i].src2_preg;
                    entries_next[wr_slot].uses_src2 = enq_uops[i].uses_src2;
                    entries_next[wr_slot].status    = ENTRY_READY;
                    wr_slot = wr_slot + 1'b1;
                end
            end
        end

        // issue marks first, so a writeback to the same slot overrides them
        for (int u = 0; u < NUM_ISSUE_UNITS; u++) begin
            if (issue_marks[u].valid && entries[issue_marks[u].ptr].status == ENTRY_READY) begin
                entries_next[issue_marks[u].ptr].status = ENTRY_ISSUED;
            end
        end

        for (int w = 0; w < WB_PORTS; w++) begin
            if (wb[w].valid && entries[wb[w].ptr].status != ENTRY_FREE) begin
                entries_next[wb[w].ptr].status = ENTRY_DONE;
            end
        end

        // release retired slots from head
        for (int r = 0; r < COMMIT_WIDTH; r++) begin
            if (RET_CNT_W'(r) < retire_cnt) begin
                entries_next[free_slot].status = ENTRY_FREE;
            end
            free_slot = free_slot + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_N_in || flush) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].status <= ENTRY_FREE;  // payload left as is
            end
        end else begin
            entries <= entries_next;
        end
    end

endmodule

// File: src/rob_issue_select.sv
`timescale 1ns/10ps

module rob_issue_select #(
    parameter rob_pkg::unit_e unit_class = rob_pkg::UNIT_ALU
) (
    input  logic                                           clk_in,
    input  logic                                           rst_N_in,
    input  logic                                           flush,
    input  logic                                           unit_ready,
    input  rob_pkg::rob_entry_t [rob_pkg::ROB_DEPTH-1:0]     entries,
    input  logic                [rob_pkg::ROB_PTR_W-1:0]     head,
    input  logic                [rob_pkg::NUM_PHYS_REGS-1:0] scoreboard,
    output rob_pkg::rob_issue_t                            issue,
    output rob_pkg::issue_mark_t                           issue_mark
);

    import rob_pkg::*;

    logic [ROB_DEPTH-1:0] candidate;  // per slot, indexed by slot number
    logic                 found;
    logic                 pick;
    logic [ROB_PTR_W-1:0] sel_ptr;
    logic [ROB_PTR_W-1:0] scan_idx;
    rob_entry_t           sel_entry;

    // a slot qualifies when it waits for this unit with its sources ready
    for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_cand
        logic src1_ok;
        logic src2_ok;

        assign src1_ok = scoreboard[entries[i].src1_preg];
        assign src2_ok = !entries[i].uses_src2 || scoreboard[entries[i].src2_preg];

        assign candidate[i] = (entries[i].status == ENTRY_READY)
                           && (entries[i].unit == unit_class)
                           && src1_ok && src2_ok;
    end

    // walk from head so the first hit is the oldest
    always_comb begin
        found    = 1'b0;
        sel_ptr  = head;
        scan_idx = head;
        for (int k = 0; k < ROB_DEPTH; k++) begin
            scan_idx = head + ROB_PTR_W'(k);
            if (!found && candidate[scan_idx]) begin
                found   = 1'b1;
                sel_ptr = scan_idx;
            end
        end
    end

    assign sel_entry = entries[sel_ptr];
    assign pick      = found && unit_ready;  // unit busy, entry stays ready

    // the store marks the entry at the same edge the pulse is registered
    assign issue_mark.valid = pick;
    assign issue_mark.ptr   = sel_ptr;

    always_ff @(posedge clk_in) begin
        if (rst_N_in || flush) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= pick;  // one cycle pulse
            if (pick) begin
                issue.ptr       <= sel_ptr;
                issue.opcode    <= sel_entry.opcode;
                issue.dest_preg <= sel_entry.dest_preg;
                issue.src1_preg <= sel_entry.src1_preg;
                issue.src2_preg <= sel_entry.src2_preg;
            end
        end
    end

endmodule

// File: src/rob_commit.sv
`timescale 1ns/10ps

module rob_commit (
    input  logic                                           clk_in,
    input  logic                                           rst_N_in,
    input  logic                                           flush,
    input  rob_pkg::rob_entry_t  [rob_pkg::ROB_DEPTH-1:0]    entries,
    input  logic                 [rob_pkg::ROB_PTR_W-1:0]    head,
    input  logic                                           empty,
    output logic                 [rob_pkg::RET_CNT_W-1:0]    retire_cnt,
    output rob_pkg::rob_commit_t [rob_pkg::COMMIT_WIDTH-1:0] commit
);

    import rob_pkg::*;

    logic [ROB_PTR_W-1:0] next_ptr;
    rob_entry_t           old_entry;  // at head
    rob_entry_t           young_entry;
    logic                 ret_old;
    logic                 ret_young;

    assign next_ptr    = head + 1'b1;
    assign old_entry   = entries[head];
    assign young_entry = entries[next_ptr];

    // strict order, the younger one only goes together with the older
    assign ret_old    = !empty && (old_entry.status == ENTRY_DONE);
    assign ret_young  = ret_old && (young_entry.status == ENTRY_DONE);
    assign retire_cnt = {ret_old && ret_young, ret_old && !ret_young};

    always_ff @(posedge clk_in) begin
        if (rst_N_in || flush) begin
            commit[0].valid <= 1'b0;
            commit[1].valid <= 1'b0;
        end else begin
            commit[0].valid     <= ret_old;  // slot 0 is the older one
            commit[0].dest_preg <= old_entry.dest_preg;
            commit[0].opcode    <= old_entry.opcode;
            commit[1].valid     <= ret_young;
            commit[1].dest_preg <= young_entry.dest_preg;
            commit[1].opcode    <= young_entry.opcode;
        end
    end

endmodule

// File: src/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer (
    input  logic                                           clk_in,
    input  logic                                           rst_N_in,
    input  logic                                           flush,
    input  rob_pkg::rob_uop_t    [rob_pkg::ENQ_WIDTH-1:0]    enq_uops,
    input  logic                                           alu_ready,
    input  logic                                           lsu_ready,
    input  logic                                           bru_ready,
    input  rob_pkg::rob_wb_t     [rob_pkg::WB_PORTS-1:0]     wb,
    input  logic                 [rob_pkg::NUM_PHYS_REGS-1:0] scoreboard,
    output logic                                           rob_ready,
    output logic                                           empty,
    output rob_pkg::rob_issue_t                            alu_issue,
    output rob_pkg::rob_issue_t                            lsu_issue,
    output rob_pkg::rob_issue_t                            bru_issue,
    output rob_pkg::rob_commit_t [rob_pkg::COMMIT_WIDTH-1:0] commit
);

    import rob_pkg::*;

    logic        [ENQ_WIDTH-1:0]       enq_valid;
    logic        [ROB_PTR_W-1:0]       head;
    logic        [ROB_PTR_W-1:0]       enq_ptr;
    logic                              enq_accept;
    logic        [RET_CNT_W-1:0]       retire_cnt;
    rob_entry_t  [ROB_DEPTH-1:0]       entries;
    issue_mark_t [NUM_ISSUE_UNITS-1:0] issue_marks;  // alu, lsu, bru

    for (genvar i = 0; i < ENQ_WIDTH; i++) begin : g_enq_valid
        assign enq_valid[i] = enq_uops[i].valid;
    end

    rob_ptr_ctrl u_ptr_ctrl (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .flush      (flush),
        .enq_valid  (enq_valid),
        .retire_cnt (retire_cnt),
        .head       (head),
        .enq_ptr    (enq_ptr),
        .enq_accept (enq_accept),
        .rob_ready  (rob_ready),
        .empty      (empty)
    );

    rob_entry_store u_store (
        .clk_in      (clk_in),
        .rst_N_in    (rst_N_in),
        .flush       (flush),
        .enq_uops    (enq_uops),
        .enq_ptr     (enq_ptr),
        .enq_accept  (enq_accept),
        .wb          (wb),
        .issue_marks (issue_marks),
        .head        (head),
        .retire_cnt  (retire_cnt),
        .entries     (entries)
    );

    rob_issue_select #(.unit_class(UNIT_ALU)) u_alu_sel (
        .clk_in (clk_in), .rst_N_in (rst_N_in), .flush (flush),
        .unit_ready (alu_ready), .entries (entries), .head (head),
        .scoreboard (scoreboard), .issue (alu_issue), .issue_mark (issue_marks[0])
    );

    rob_issue_select #(.unit_class(UNIT_LSU)) u_lsu_sel (
        .clk_in (clk_in), .rst_N_in (rst_N_in), .flush (flush),
        .unit_ready (lsu_ready), .entries (entries), .head (head),
        .scoreboard (scoreboard), .issue (lsu_issue), .issue_mark (issue_marks[1])
    );

    rob_issue_select #(.unit_class(UNIT_BRU)) u_bru_sel (
        .clk_in (clk_in), .rst_N_in (rst_N_in), .flush (flush),
        .unit_ready (bru_ready), .entries (entries), .head (head),
        .scoreboard (scoreboard), .issue (bru_issue), .issue_mark (issue_marks[2])
    );

    rob_commit u_commit (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .flush      (flush),
        .entries    (entries),
        .head       (head),
        .empty      (empty),
        .retire_cnt (retire_cnt),
        .commit     (commit)
    );

endmodule

// File: bench/rob_tb.sv
`timescale 1ns/10ps

module rob_tb;

    import rob_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int WAIT_LIMIT  = 200;  // cycles per wait loop
    localparam int POISON_BASE = 60;   // dests only used by the rejected group

    logic                                clk_in = 1'b0;
    logic                                rst_N_in;
    logic                                flush;
    rob_uop_t    [ENQ_WIDTH-1:0]         enq_uops;
    logic                                alu_ready, lsu_ready, bru_ready;
    rob_wb_t     [WB_PORTS-1:0]          wb;
    logic        [NUM_PHYS_REGS-1:0]     scoreboard;
    logic                                rob_ready, empty;
    rob_issue_t                          alu_issue, lsu_issue, bru_issue;
    rob_commit_t [COMMIT_WIDTH-1:0]      commit;
    logic                                quiet;

    // queue model of the buffer
    int  m_dest [ROB_DEPTH];
    int  m_op [ROB_DEPTH];
    int  m_src1 [ROB_DEPTH];
    int  m_src2 [ROB_DEPTH];
    int  m_unit [ROB_DEPTH];
    bit  m_live [ROB_DEPTH];
    bit  m_issued [ROB_DEPTH];
    time m_issue_t [ROB_DEPTH];
    int  m_tail, m_head;
    int  exp_commit_q[$];  // dest_preg in age order

    int    err_cnt, err_at_start, tests_run, tests_failed;
    int    commit_total, pair_commits;
    string test_name;

    reorder_buffer DUT (
        .clk_in (clk_in), .rst_N_in (rst_N_in), .flush (flush), .enq_uops (enq_uops),
        .alu_ready (alu_ready), .lsu_ready (lsu_ready), .bru_ready (bru_ready),
        .wb (wb), .scoreboard (scoreboard), .rob_ready (rob_ready), .empty (empty),
        .alu_issue (alu_issue), .lsu_issue (lsu_issue), .bru_issue (bru_issue),
        .commit (commit)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    assign quiet = !(alu_issue.valid || lsu_issue.valid || bru_issue.valid
                     || commit[0].valid || commit[1].valid);

    // sampled on the falling edge where ports are settled
    a_reset: assert property (@(negedge clk_in) rst_N_in |-> (quiet && empty && rob_ready))
        else log_failure("outputs active during reset");
    a_flush: assert property (@(negedge clk_in) disable iff (rst_N_in)
                              flush |-> (quiet && empty && rob_ready))
        else log_failure("pulse or state left after flush");
    a_order: assert property (@(negedge clk_in) disable iff (rst_N_in)
                              commit[1].valid |-> commit[0].valid)
        else log_failure("younger commit without older");
    a_empty: assert property (@(negedge clk_in) disable iff (rst_N_in) empty |-> rob_ready)
        else log_failure("empty but not ready");
    a_alu_bp: assert property (@(negedge clk_in) !alu_ready |-> !alu_issue.valid)
        else log_failure("alu issue while unit busy");
    a_lsu_bp: assert property (@(negedge clk_in) !lsu_ready |-> !lsu_issue.valid)
        else log_failure("lsu issue while unit busy");
    a_bru_bp: assert property (@(negedge clk_in) !bru_ready |-> !bru_issue.valid)
        else log_failure("bru issue while unit busy");
    a_reject: assert property (@(negedge clk_in)
                               (!commit[0].valid || commit[0].dest_preg < POISON_BASE)
                               && (!commit[1].valid || commit[1].dest_preg < POISON_BASE))
        else log_failure("rejected group reached commit");

    task automatic log_failure(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic expect_true(input bit cond, input string msg);
        assert (cond) else log_failure(msg);
    endtask

    task automatic report_timeout(input string msg);
        $display("timeout: %s", msg);
        err_cnt++;
    endtask

    task automatic check_issue(input rob_issue_t iss, input unit_e u);
        if (iss.valid) begin
            expect_true(m_live[iss.ptr] && !m_issued[iss.ptr],
                        $sformatf("slot %0d issued while not waiting", iss.ptr));
            expect_true(m_unit[iss.ptr] == int'(u),
                        $sformatf("slot %0d issued on wrong unit %0d", iss.ptr, u));
            expect_true(iss.dest_preg == m_dest[iss.ptr],
                        $sformatf("slot %0d dest %0d, expected %0d", iss.ptr, iss.dest_preg,
                                  m_dest[iss.ptr]));
            expect_true(iss.opcode == m_op[iss.ptr],
                        $sformatf("slot %0d opcode %0h, expected %0h", iss.ptr, iss.opcode,
                                  m_op[iss.ptr]));
            expect_true(iss.src1_preg == m_src1[iss.ptr] && iss.src2_preg == m_src2[iss.ptr],
                        $sformatf("slot %0d sources %0d %0d, expected %0d %0d", iss.ptr,
                                  iss.src1_preg, iss.src2_preg, m_src1[iss.ptr],
                                  m_src2[iss.ptr]));
            m_issued[iss.ptr]  = 1'b1;
            m_issue_t[iss.ptr] = $time;
        end
    endtask

    task automatic check_commit(input rob_commit_t c);
        int exp_dest;
        if (exp_commit_q.size() == 0) begin
            expect_true(1'b0, "commit with no entry outstanding");
        end else begin
            exp_dest = exp_commit_q.pop_front();
            expect_true(c.dest_preg == exp_dest,
                        $sformatf("commit dest %0d, expected %0d", c.dest_preg, exp_dest));
            expect_true(c.opcode == m_op[m_head],
                        $sformatf("commit opcode %0h, expected %0h", c.opcode, m_op[m_head]));
            expect_true(m_issued[m_head], $sformatf("slot %0d committed unissued", m_head));
            m_live[m_head] = 1'b0;
            m_head = (m_head + 1) % ROB_DEPTH;
            commit_total++;
        end
    endtask

    always @(negedge clk_in) begin
        if (!rst_N_in) begin
            check_issue(alu_issue, UNIT_ALU);
            check_issue(lsu_issue, UNIT_LSU);
            check_issue(bru_issue, UNIT_BRU);
            if (commit[0].valid && commit[1].valid) pair_commits++;
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (commit[c].valid) check_commit(commit[c]);
            end
        end
    end

    function automatic rob_uop_t rand_uop(input unit_e u, input int src1);
        rob_uop_t r;
        r.valid     = 1'b1;
        r.opcode    = 8'($urandom);
        r.unit      = u;
        r.dest_preg = PREG_W'($urandom_range(47));
        r.src1_preg = PREG_W'(src1);
        r.src2_preg = PREG_W'($urandom_range(47));
        r.uses_src2 = 1'($urandom);
        return r;
    endfunction

    function automatic unit_e any_unit();
        return unit_e'($urandom_range(2));
    endfunction

    task automatic record_uop(input rob_uop_t u, output int slot);
        slot              = m_tail;
        m_dest[slot]      = u.dest_preg;
        m_op[slot]        = u.opcode;
        m_src1[slot]      = u.src1_preg;
        m_src2[slot]      = u.src2_preg;
        m_unit[slot]      = int'(u.unit);
        m_live[slot]      = 1'b1;
        m_issued[slot]    = 1'b0;
        exp_commit_q.push_back(u.dest_preg);
        m_tail = (m_tail + 1) % ROB_DEPTH;
    endtask

    // a second slot with valid low leaves pb at -1
    task automatic enqueue_pair(input rob_uop_t a, input rob_uop_t b, output int pa,
                                output int pb);
        int n;
        n  = 0;
        pb = -1;
        @(negedge clk_in);
        while (!rob_ready && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (!rob_ready) report_timeout("rob_ready never rose for enqueue");
        enq_uops[0] = a;
        enq_uops[1] = b;
        record_uop(a, pa);
        if (b.valid) record_uop(b, pb);
        @(negedge clk_in);
        enq_uops = '0;
    endtask

    task automatic writeback(input int p0, input int p1);
        @(negedge clk_in);
        wb[0].valid = (p0 >= 0);
        wb[0].ptr   = ROB_PTR_W'(p0);
        wb[1].valid = (p1 >= 0);
        wb[1].ptr   = ROB_PTR_W'(p1);
        @(negedge clk_in);
        wb = '0;
    endtask

    task automatic wait_issued(input int p);
        int n;
        n = 0;
        while (!m_issued[p] && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (!m_issued[p]) report_timeout($sformatf("slot %0d never issued", p));
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_commit_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (exp_commit_q.size() != 0) report_timeout("entries never committed");
    endtask

    task automatic do_flush();
        @(negedge clk_in);
        flush = 1'b1;
        @(negedge clk_in);
        flush = 1'b0;
        exp_commit_q.delete();
        m_tail = 0;
        m_head = 0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            m_live[i]   = 1'b0;
            m_issued[i] = 1'b0;
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == err_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed", test_name);
        end
    endtask

    initial begin
        int slots [ROB_DEPTH];
        int pa, pb, pc, pd, pairs0, base;
        time t_set;

        void'($urandom(32'ha19f));
        rst_N_in   = 1'b1;
        flush      = 1'b0;
        enq_uops   = '0;
        wb         = '0;
        alu_ready  = 1'b1;
        lsu_ready  = 1'b1;
        bru_ready  = 1'b1;
        scoreboard = '1;
        repeat (5) @(negedge clk_in);
        rst_N_in = 1'b0;

        begin_test("fill_and_ready");
        expect_true(rob_ready && empty && quiet, "not idle after reset");
        for (int i = 0; i < ROB_DEPTH; i += 2) begin
            enqueue_pair(rand_uop(any_unit(), $urandom_range(47)),
                         rand_uop(any_unit(), $urandom_range(47)), slots[i], slots[i+1]);
        end
        expect_true(!rob_ready && !empty, "rob_ready still high with 16 entries");
        @(negedge clk_in);
        enq_uops[0]           = rand_uop(UNIT_ALU, 1);
        enq_uops[0].dest_preg = PREG_W'(POISON_BASE);
        enq_uops[1]           = rand_uop(UNIT_BRU, 2);
        enq_uops[1].dest_preg = PREG_W'(POISON_BASE + 1);
        @(negedge clk_in);
        enq_uops = '0;
        for (int i = 0; i < ROB_DEPTH; i++) wait_issued(slots[i]);
        for (int i = 0; i < ROB_DEPTH; i += 2) writeback(slots[i], slots[i+1]);
        wait_drained();
        @(negedge clk_in);
        expect_true(empty && rob_ready, "not empty after draining");
        end_test();

        begin_test("scoreboard_gating");
        scoreboard[63] = 1'b0;  // older entry waits on this source
        enqueue_pair(rand_uop(UNIT_ALU, 63), rand_uop(UNIT_ALU, $urandom_range(47)), pa, pb);
        enq_uops = '0;
        wait_issued(pb);
        repeat (3) @(negedge clk_in);
        expect_true(!m_issued[pa], "alu entry issued with source not ready");
        scoreboard[63] = 1'b1;
        t_set = $time;
        wait_issued(pa);
        expect_true(m_issue_t[pa] == t_set + CLK_PERIOD, "older entry issued late");
        expect_true(m_issue_t[pb] < m_issue_t[pa], "younger entry did not go first");
        writeback(pa, pb);
        wait_drained();
        end_test();

        begin_test("parallel_issue");
        alu_ready = 1'b0;
        lsu_ready = 1'b0;
        bru_ready = 1'b0;
        enqueue_pair(rand_uop(UNIT_ALU, 3), rand_uop(UNIT_LSU, 4), pa, pb);
        enqueue_pair(rand_uop(UNIT_BRU, 5), '0, pc, pd);
        repeat (2) @(negedge clk_in);
        {alu_ready, lsu_ready, bru_ready} = 3'b111;
        t_set = $time;
        wait_issued(pa);
        wait_issued(pb);
        wait_issued(pc);
        expect_true(m_issue_t[pa] == t_set + CLK_PERIOD && m_issue_t[pb] == m_issue_t[pa]
                    && m_issue_t[pc] == m_issue_t[pa], "unit issues not in one cycle");
        writeback(pa, pb);
        writeback(pc, -1);
        wait_drained();
        end_test();

        begin_test("unit_backpressure");
        lsu_ready = 1'b0;
        enqueue_pair(rand_uop(UNIT_LSU, 7), '0, pa, pb);
        repeat (4) @(negedge clk_in);
        expect_true(!m_issued[pa], "lsu entry issued while lsu busy");
        lsu_ready = 1'b1;
        wait_issued(pa);
        writeback(pa, -1);
        wait_drained();
        end_test();

        begin_test("in_order_commit");
        enqueue_pair(rand_uop(UNIT_ALU, 8), rand_uop(UNIT_ALU, 9), pa, pb);
        wait_issued(pa);
        wait_issued(pb);
        base   = commit_total;
        pairs0 = pair_commits;
        writeback(pb, -1);
        repeat (3) @(negedge clk_in);
        expect_true(commit_total == base && !empty, "younger entry committed first");
        writeback(pa, -1);
        wait_drained();
        expect_true(pair_commits == pairs0 + 1 && commit_total == base + 2,
                    "pair did not commit in one cycle");
        end_test();

        begin_test("flush");
        scoreboard[63] = 1'b0;
        enqueue_pair(rand_uop(UNIT_ALU, 63), rand_uop(UNIT_LSU, 10), pa, pb);
        wait_issued(pb);
        writeback(pb, -1);  // done but stuck behind the head
        base = commit_total;
        do_flush();
        expect_true(empty && rob_ready, "buffer not empty after flush");
        scoreboard[63] = 1'b1;
        repeat (4) @(negedge clk_in);
        expect_true(commit_total == base, "flushed entry committed");
        enqueue_pair(rand_uop(UNIT_ALU, 11), rand_uop(UNIT_BRU, 12), pa, pb);
        wait_issued(pa);
        wait_issued(pb);
        writeback(pa, pb);
        wait_drained();
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
src/rob_pkg.sv
src/rob_ptr_ctrl.sv
src/rob_entry_store.sv
src/rob_issue_select.sv
src/rob_commit.sv
src/reorder_buffer.sv
bench/rob_tb.sv
